//--- fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Major opcode and format for the OP-FP group
`define FPU_OPCODE_FP   7'b1010011
`define FMT_S           2'b00

// funct5 groups, instr[31:27]
`define FUNCT5_FSGNJ    5'b00100
`define FUNCT5_FMINMAX  5'b00101
`define FUNCT5_FCMP     5'b10100
`define FUNCT5_FMV_X    5'b11100
`define FUNCT5_FMV_W    5'b11110

// funct3 variants inside each group
`define FUNCT3_FSGNJ    3'b000
`define FUNCT3_FSGNJN   3'b001
`define FUNCT3_FSGNJX   3'b010
`define FUNCT3_FMIN     3'b000
`define FUNCT3_FMAX     3'b001
`define FUNCT3_FEQ      3'b010
`define FUNCT3_FLT      3'b001
`define FUNCT3_FLE      3'b000
`define FUNCT3_FMV      3'b000
`define FUNCT3_FCLASS   3'b001

// CSR map
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003

`define FLAG_NV         4       // Invalid operation, MSB of fflags
`define FP_QNAN         32'h7fc00000

`endif

//--- fpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_core (
  input  wire                  clk,
  input  wire                  rst,
  input  logic                 valid_i,
  input  fpu_pkg::fp_word_t    instr_i,
  input  fpu_pkg::fp_word_t    int_rdata_i,
  input  logic                 csr_rden_i,
  input  fpu_pkg::csr_addr_t   csr_raddr_i,
  input  logic                 csr_wren_i,
  input  fpu_pkg::csr_addr_t   csr_waddr_i,
  input  fpu_pkg::fp_word_t    csr_wdata_i,
  output logic                 illegal_o,
  output fpu_pkg::fp_wb_t      int_wb_o,
  output fpu_pkg::fp_word_t    csr_rdata_o,
  output logic                 csr_ready_o
);

  fpu_pkg::fp_decode_t   dec;
  fpu_pkg::fp_operands_t opnd;
  fpu_pkg::fp_wb_t       fp_wb;     // Registered FP write-back, also the bypass source
  fpu_pkg::fflags_t      fflags;
  logic                  flags_valid;

  // Decode and operand fetch side by side
  fpu_decode u_decode (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  fpu_regfile u_regfile (
    .clk     (clk),
    .rs1_i   (dec.rs1),
    .rs2_i   (dec.rs2),
    .rden1_i (dec.frden1),
    .rden2_i (dec.frden2),
    .wb_i    (fp_wb),
    .opnd_o  (opnd)
  );

  fpu_misc_exe u_exe (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (valid_i),
    .dec_i         (dec),
    .opnd_i        (opnd),
    .int_rdata_i   (int_rdata_i),
    .fp_wb_o       (fp_wb),
    .int_wb_o      (int_wb_o),
    .flags_valid_o (flags_valid),
    .fflags_o      (fflags),
    .illegal_o     (illegal_o)
  );

  fpu_csr u_csr (
    .clk           (clk),
    .rst           (rst),
    .flags_valid_i (flags_valid),
    .fflags_i      (fflags),
    .csr_rden_i    (csr_rden_i),
    .csr_wren_i    (csr_wren_i),
    .csr_raddr_i   (csr_raddr_i),
    .csr_waddr_i   (csr_waddr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .csr_ready_o   (csr_ready_o)
  );

endmodule

`default_nettype wire

//--- fpu_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_csr (
  input  wire                  clk,
  input  wire                  rst,
  input  logic                 flags_valid_i,
  input  fpu_pkg::fflags_t     fflags_i,
  input  logic                 csr_rden_i,
  input  logic                 csr_wren_i,
  input  fpu_pkg::csr_addr_t   csr_raddr_i,
  input  fpu_pkg::csr_addr_t   csr_waddr_i,
  input  fpu_pkg::fp_word_t    csr_wdata_i,
  output fpu_pkg::fp_word_t    csr_rdata_o,
  output logic                 csr_ready_o
);

  fpu_pkg::frm_t    frm_q, frm_d;
  fpu_pkg::fflags_t fflags_q, fflags_d;

  // ==============================
  // Read port
  // ==============================
  always_comb begin
    csr_rdata_o = '0;
    csr_ready_o = 1'b0;
    if (csr_rden_i) begin
      case (csr_raddr_i)
        `CSR_FFLAGS: begin
          csr_rdata_o = {27'd0, fflags_q};
          csr_ready_o = 1'b1;
        end
        `CSR_FRM: begin
          csr_rdata_o = {29'd0, frm_q};
          csr_ready_o = 1'b1;
        end
        `CSR_FCSR: begin
          csr_rdata_o = {24'd0, frm_q, fflags_q};   // frm above fflags
          csr_ready_o = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // ==============================
  // Write port and flag accumulation
  // ==============================
  always_comb begin
    frm_d    = frm_q;
    fflags_d = fflags_q;
    if (csr_wren_i) begin
      case (csr_waddr_i)
        `CSR_FFLAGS: fflags_d = csr_wdata_i[4:0];
        `CSR_FRM:    frm_d    = csr_wdata_i[2:0];
        `CSR_FCSR: begin
          fflags_d = csr_wdata_i[4:0];
          frm_d    = csr_wdata_i[7:5];
        end
        default: ;
      endcase
    end
    if (flags_valid_i) fflags_d = fflags_d | fflags_i;   // Sticky, lands over a write
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      frm_q    <= '0;
      fflags_q <= '0;
    end else begin
      frm_q    <= frm_d;
      fflags_q <= fflags_d;
    end
  end

endmodule

`default_nettype wire

//--- fpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_decode (
  input  fpu_pkg::fp_word_t   instr_i,
  output fpu_pkg::fp_decode_t dec_o
);

  logic [6:0] opcode;
  logic [1:0] fmt;
  logic [4:0] funct5;
  logic [2:0] funct3;
  logic       legal;

  assign opcode = instr_i[6:0];
  assign fmt    = instr_i[26:25];
  assign funct5 = instr_i[31:27];
  assign funct3 = instr_i[14:12];

  always_comb begin
    dec_o         = '0;
    dec_o.op      = fpu_pkg::FSGNJ;
    dec_o.rs1     = instr_i[19:15];
    dec_o.rs2     = instr_i[24:20];
    dec_o.rd      = instr_i[11:7];
    legal         = 1'b0;

    if (opcode == `FPU_OPCODE_FP && fmt == `FMT_S) begin
      case (funct5)
        `FUNCT5_FSGNJ: begin
          legal        = 1'b1;
          dec_o.fwren  = 1'b1;
          dec_o.frden1 = 1'b1;
          dec_o.frden2 = 1'b1;
          case (funct3)
            `FUNCT3_FSGNJ:  dec_o.op = fpu_pkg::FSGNJ;
            `FUNCT3_FSGNJN: dec_o.op = fpu_pkg::FSGNJN;
            `FUNCT3_FSGNJX: dec_o.op = fpu_pkg::FSGNJX;
            default:        legal = 1'b0;
          endcase
        end
        `FUNCT5_FMINMAX: begin
          legal        = 1'b1;
          dec_o.fwren  = 1'b1;
          dec_o.frden1 = 1'b1;
          dec_o.frden2 = 1'b1;
          case (funct3)
            `FUNCT3_FMIN: dec_o.op = fpu_pkg::FMIN;
            `FUNCT3_FMAX: dec_o.op = fpu_pkg::FMAX;
            default:      legal = 1'b0;
          endcase
        end
        `FUNCT5_FCMP: begin
          legal        = 1'b1;
          dec_o.wren   = 1'b1;   // Result goes to x[rd]
          dec_o.frden1 = 1'b1;
          dec_o.frden2 = 1'b1;
          case (funct3)
            `FUNCT3_FEQ: dec_o.op = fpu_pkg::FEQ;
            `FUNCT3_FLT: dec_o.op = fpu_pkg::FLT;
            `FUNCT3_FLE: dec_o.op = fpu_pkg::FLE;
            default:     legal = 1'b0;
          endcase
        end
        `FUNCT5_FMV_X: begin
          // Single source, rs2 field must be zero
          legal        = (instr_i[24:20] == 5'd0);
          dec_o.wren   = 1'b1;
          dec_o.frden1 = 1'b1;
          case (funct3)
            `FUNCT3_FMV:    dec_o.op = fpu_pkg::FMV_X_W;
            `FUNCT3_FCLASS: dec_o.op = fpu_pkg::FCLASS;
            default:        legal = 1'b0;
          endcase
        end
        `FUNCT5_FMV_W: begin
          // Integer source comes in on the side port
          legal       = (instr_i[24:20] == 5'd0) && (funct3 == `FUNCT3_FMV);
          dec_o.fwren = 1'b1;
          dec_o.op    = fpu_pkg::FMV_W_X;
        end
        default: legal = 1'b0;
      endcase
    end

    // Anything unrecognised leaves no side effects
    if (!legal) begin
      dec_o.op      = fpu_pkg::FSGNJ;
      dec_o.fwren   = 1'b0;
      dec_o.wren    = 1'b0;
      dec_o.frden1  = 1'b0;
      dec_o.frden2  = 1'b0;
      dec_o.illegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- fpu_misc_exe.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_misc_exe (
  input  wire                    clk,
  input  wire                    rst,
  input  logic                   valid_i,
  input  fpu_pkg::fp_decode_t    dec_i,
  input  fpu_pkg::fp_operands_t  opnd_i,
  input  fpu_pkg::fp_word_t      int_rdata_i,
  output fpu_pkg::fp_wb_t        fp_wb_o,
  output fpu_pkg::fp_wb_t        int_wb_o,
  output logic                   flags_valid_o,
  output fpu_pkg::fflags_t       fflags_o,
  output logic                   illegal_o
);

  fpu_pkg::fp_word_t a, b;
  fpu_pkg::fp_word_t sgnj_res;
  fpu_pkg::fp_word_t minmax_res;
  fpu_pkg::fp_word_t result;
  fpu_pkg::fflags_t  flags;
  logic [9:0] cls1, cls2;
  logic       nan1, nan2, any_nan, any_snan;
  logic       both_zero, a_less;
  logic       feq_r, flt_r, fle_r;
  logic       flag_op;

  // One-hot FCLASS mask from bit 0 for -inf up to bit 9 for quiet NaN
  function automatic logic [9:0] fp_class(input fpu_pkg::fp_word_t w);
    logic       exp_zero;
    logic       exp_ones;
    logic       man_zero;
    logic [9:0] m;
    exp_zero = (w[30:23] == 8'h00);
    exp_ones = (w[30:23] == 8'hff);
    man_zero = (w[22:0] == 23'd0);
    m        = '0;
    if (exp_ones && !man_zero) m[w[22] ? 9 : 8] = 1'b1;
    else if (exp_ones)         m[w[31] ? 0 : 7] = 1'b1;
    else if (exp_zero && man_zero) m[w[31] ? 3 : 4] = 1'b1;
    else if (exp_zero)         m[w[31] ? 2 : 5] = 1'b1;
    else                       m[w[31] ? 1 : 6] = 1'b1;
    return m;
  endfunction

  // ==============================
  // Operand analysis
  // ==============================
  assign a         = opnd_i.data1;
  assign b         = opnd_i.data2;
  assign cls1      = fp_class(a);
  assign cls2      = fp_class(b);
  assign nan1      = cls1[8] | cls1[9];
  assign nan2      = cls2[8] | cls2[9];
  assign any_nan   = nan1 | nan2;
  assign any_snan  = cls1[8] | cls2[8];
  assign both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);

  // Total order on non-NaN values where -0 sorts below +0
  assign a_less = (a[31] != b[31]) ? a[31] :
                  a[31]            ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);

  assign feq_r = !any_nan && ((a == b) || both_zero);
  assign flt_r = !any_nan && a_less && !both_zero;
  assign fle_r = flt_r | feq_r;

  always_comb begin
    case (dec_i.op)
      fpu_pkg::FSGNJN: sgnj_res = {~b[31], a[30:0]};
      fpu_pkg::FSGNJX: sgnj_res = {a[31] ^ b[31], a[30:0]};
      default:         sgnj_res = {b[31], a[30:0]};
    endcase

    if (nan1 && nan2)  minmax_res = `FP_QNAN;
    else if (nan1)     minmax_res = b;
    else if (nan2)     minmax_res = a;
    else if (dec_i.op == fpu_pkg::FMIN) minmax_res = a_less ? a : b;
    else               minmax_res = a_less ? b : a;
  end

  // ==============================
  // Result and flags
  // ==============================
  always_comb begin
    flags   = '0;
    flag_op = 1'b0;
    case (dec_i.op)
      fpu_pkg::FMIN, fpu_pkg::FMAX: begin
        result             = minmax_res;
        flag_op            = 1'b1;
        flags[`FLAG_NV]    = any_snan;
      end
      fpu_pkg::FEQ: begin
        result             = {31'd0, feq_r};
        flag_op            = 1'b1;
        flags[`FLAG_NV]    = any_snan;   // Quiet compare
      end
      fpu_pkg::FLT, fpu_pkg::FLE: begin
        result             = {31'd0, (dec_i.op == fpu_pkg::FLT) ? flt_r : fle_r};
        flag_op            = 1'b1;
        flags[`FLAG_NV]    = any_nan;    // Signaling compare
      end
      fpu_pkg::FCLASS:  result = {22'd0, cls1};
      fpu_pkg::FMV_X_W: result = a;
      fpu_pkg::FMV_W_X: result = int_rdata_i;
      default:          result = sgnj_res;
    endcase
  end

  // One-cycle strobes per issued instruction
  always_ff @(posedge clk) begin
    fp_wb_o.addr  <= dec_i.rd;
    fp_wb_o.data  <= result;
    int_wb_o.addr <= dec_i.rd;
    int_wb_o.data <= result;
    fflags_o      <= flags;
    if (!rst) begin
      fp_wb_o.wren  <= 1'b0;
      int_wb_o.wren <= 1'b0;
      flags_valid_o <= 1'b0;
      illegal_o     <= 1'b0;
    end else begin
      fp_wb_o.wren  <= valid_i & dec_i.fwren;
      int_wb_o.wren <= valid_i & dec_i.wren;
      flags_valid_o <= valid_i & flag_op & ~dec_i.illegal;
      illegal_o     <= valid_i & dec_i.illegal;
    end
  end

  // Every op targets exactly one register file
  one_wb_target_a: assert property (
    @(posedge clk) disable iff (!rst) !(fp_wb_o.wren && int_wb_o.wren)
  ) else $error("FP and integer write-back enabled together");

endmodule

`default_nettype wire

//--- fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  // ==============================
  // Plain vector types
  // ==============================
  typedef logic [31:0] fp_word_t;   // FP or integer data word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  fflags_t;    // NV DZ OF UF NX
  typedef logic [2:0]  frm_t;

  // ==============================
  // Operations handled by this unit
  // ==============================
  typedef enum logic [3:0] {
    FSGNJ   = 4'd0,
    FSGNJN  = 4'd1,
    FSGNJX  = 4'd2,
    FMIN    = 4'd3,
    FMAX    = 4'd4,
    FEQ     = 4'd5,
    FLT     = 4'd6,
    FLE     = 4'd7,
    FCLASS  = 4'd8,
    FMV_X_W = 4'd9,
    FMV_W_X = 4'd10
  } fp_op_e;

  // ==============================
  // Bundles between stages
  // ==============================
  typedef struct packed {
    fp_op_e    op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      frden1;
    logic      frden2;
    logic      fwren;    // Write FP register
    logic      wren;     // Write integer register
    logic      illegal;
  } fp_decode_t;

  typedef struct packed {
    fp_word_t data1;
    fp_word_t data2;
  } fp_operands_t;

  typedef struct packed {
    logic      wren;
    reg_addr_t addr;
    fp_word_t  data;
  } fp_wb_t;

endpackage

`default_nettype wire

//--- fpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_regfile (
  input  wire                    clk,
  input  fpu_pkg::reg_addr_t     rs1_i,
  input  fpu_pkg::reg_addr_t     rs2_i,
  input  logic                   rden1_i,
  input  logic                   rden2_i,
  input  fpu_pkg::fp_wb_t        wb_i,
  output fpu_pkg::fp_operands_t  opnd_o
);

  fpu_pkg::fp_word_t mem [32];

  // ==============================
  // Storage
  // ==============================
  always_ff @(posedge clk) begin
    if (wb_i.wren) begin
      mem[wb_i.addr] <= wb_i.data;
    end
  end

  // ==============================
  // Read with bypass from the write port
  // ==============================
  function automatic fpu_pkg::fp_word_t read_port(
    input fpu_pkg::reg_addr_t addr,
    input logic               en,
    input fpu_pkg::fp_word_t  stored
  );
    fpu_pkg::fp_word_t res;
    res = '0;                                 // Disabled port reads zero
    if (en) begin
      if (wb_i.wren && wb_i.addr == addr) begin
        res = wb_i.data;                      // Result still in flight
      end else begin
        res = stored;
      end
    end
    return res;
  endfunction

  always_comb begin
    opnd_o.data1 = read_port(rs1_i, rden1_i, mem[rs1_i]);
    opnd_o.data2 = read_port(rs2_i, rden2_i, mem[rs2_i]);
  end

  // A known write address is needed or the whole file gets corrupted
  wb_addr_known_a: assert property (
    @(posedge clk) wb_i.wren |-> !$isunknown(wb_i.addr)
  ) else $error("FP register write with unknown address");

endmodule

`default_nettype wire

//--- fpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_config.svh"

module fpu_tb;

  typedef struct {
    string              name;
    fpu_pkg::fp_word_t  instr;
    fpu_pkg::fp_word_t  int_rdata;
    logic               exp_wren;
    fpu_pkg::reg_addr_t exp_addr;
    fpu_pkg::fp_word_t  exp_data;
    logic               exp_illegal;
    logic               csr_rd;
    fpu_pkg::csr_addr_t csr_raddr;
    fpu_pkg::fp_word_t  exp_csr;
    logic               exp_ready;
    logic               csr_wr;
    fpu_pkg::csr_addr_t csr_waddr;
    fpu_pkg::fp_word_t  csr_wdata;
  } row_t;

  logic clk = 1'b0;
  logic rst, valid_i, csr_rden_i, csr_wren_i, illegal_o, csr_ready_o;
  fpu_pkg::fp_word_t  instr_i, int_rdata_i, csr_wdata_i, csr_rdata_o;
  fpu_pkg::csr_addr_t csr_raddr_i, csr_waddr_i;
  fpu_pkg::fp_wb_t    int_wb_o;

  row_t        rows [64];
  int          row_errs [64];
  int          n_rows = 0;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [31:0] rnd0, rnd1;

  fpu_core dut (
    .clk (clk), .rst (rst), .valid_i (valid_i), .instr_i (instr_i),
    .int_rdata_i (int_rdata_i), .csr_rden_i (csr_rden_i), .csr_raddr_i (csr_raddr_i),
    .csr_wren_i (csr_wren_i), .csr_waddr_i (csr_waddr_i), .csr_wdata_i (csr_wdata_i),
    .illegal_o (illegal_o), .int_wb_o (int_wb_o), .csr_rdata_o (csr_rdata_o),
    .csr_ready_o (csr_ready_o)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout: the test sequence did not complete within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // ==============================
  // Table building
  // ==============================
  function automatic fpu_pkg::fp_word_t enc(input logic [4:0] funct5, input logic [2:0] funct3,
                                            input logic [4:0] rd, rs1, rs2);
    return {funct5, `FMT_S, rs2, rs1, funct3, rd, `FPU_OPCODE_FP};
  endfunction

  task automatic add_row(input string name, input fpu_pkg::fp_word_t instr,
                         input fpu_pkg::fp_word_t int_rdata, input logic exp_wren,
                         input logic [4:0] exp_addr, input fpu_pkg::fp_word_t exp_data,
                         input logic exp_illegal);
    rows[n_rows].name        = name;
    rows[n_rows].instr       = instr;
    rows[n_rows].int_rdata   = int_rdata;
    rows[n_rows].exp_wren    = exp_wren;
    rows[n_rows].exp_addr    = exp_addr;
    rows[n_rows].exp_data    = exp_data;
    rows[n_rows].exp_illegal = exp_illegal;
    rows[n_rows].csr_rd      = 1'b0;
    rows[n_rows].csr_raddr   = '0;
    rows[n_rows].exp_csr     = '0;
    rows[n_rows].exp_ready   = 1'b0;
    rows[n_rows].csr_wr      = 1'b0;
    rows[n_rows].csr_waddr   = '0;
    rows[n_rows].csr_wdata   = '0;
    row_errs[n_rows]         = 0;
    n_rows++;
  endtask

  task automatic add_load(input string name, input logic [4:0] frd, input logic [31:0] value);
    add_row(name, enc(`FUNCT5_FMV_W, `FUNCT3_FMV, frd, 5'd0, 5'd0), value, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic add_int(input string name, input fpu_pkg::fp_word_t instr,
                         input logic [4:0] xrd, input logic [31:0] exp);
    add_row(name, instr, '0, 1'b1, xrd, exp, 1'b0);
  endtask

  task automatic add_move_out(input string name, input logic [4:0] frs, input logic [31:0] exp);
    add_int(name, enc(`FUNCT5_FMV_X, `FUNCT3_FMV, frs, frs, 5'd0), frs, exp);
  endtask

  // FP op into frd followed by FMV_X_W of its result
  task automatic add_fp_result(input string name, input logic [4:0] funct5,
                               input logic [2:0] funct3, input logic [4:0] frd, rs1, rs2,
                               input logic [31:0] exp);
    add_row(name, enc(funct5, funct3, frd, rs1, rs2), '0, 1'b0, '0, '0, 1'b0);
    add_move_out({name, "_rb"}, frd, exp);
  endtask

  task automatic add_cmp(input string name, input logic [2:0] funct3,
                         input logic [4:0] xrd, rs1, rs2, input logic [31:0] exp);
    add_int(name, enc(`FUNCT5_FCMP, funct3, xrd, rs1, rs2), xrd, exp);
  endtask

  task automatic csr_read(input int idx, input logic [11:0] addr, input logic [31:0] exp,
                          input logic ready);
    rows[idx].csr_rd    = 1'b1;
    rows[idx].csr_raddr = addr;
    rows[idx].exp_csr   = exp;
    rows[idx].exp_ready = ready;
  endtask

  task automatic csr_write(input int idx, input logic [11:0] addr, input logic [31:0] data);
    rows[idx].csr_wr    = 1'b1;
    rows[idx].csr_waddr = addr;
    rows[idx].csr_wdata = data;
  endtask

  // ==============================
  // Drive and check
  // ==============================
  task automatic apply_row(input int idx);
    valid_i     <= 1'b1;
    instr_i     <= rows[idx].instr;
    int_rdata_i <= rows[idx].int_rdata;
    csr_rden_i  <= rows[idx].csr_rd;
    csr_raddr_i <= rows[idx].csr_raddr;
    csr_wren_i  <= rows[idx].csr_wr;
    csr_waddr_i <= rows[idx].csr_waddr;
    csr_wdata_i <= rows[idx].csr_wdata;
  endtask

  task automatic apply_idle();
    valid_i    <= 1'b0;
    instr_i    <= '0;
    csr_rden_i <= 1'b0;
    csr_wren_i <= 1'b0;
  endtask

  task automatic check_value(input int idx, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s %s: expected %h, actual %h", rows[idx].name, what, exp, act);
      errors++;
      row_errs[idx]++;
    end
  endtask

  initial begin
    int                 i;
    fpu_pkg::fp_word_t  nv;
    logic [4:0]         cls_reg [10];
    int                 k;
    void'($urandom(32'h9ea86f4e));
    rnd0 = $urandom;
    rnd1 = $urandom;
    nv   = 32'd1 << `FLAG_NV;
    cls_reg = '{5'd8, 5'd3, 5'd11, 5'd5, 5'd4, 5'd10, 5'd1, 5'd9, 5'd7, 5'd6};

    rst = 1'b0;
    valid_i = 1'b0;
    instr_i = '0;
    int_rdata_i = '0;
    csr_rden_i = 1'b0;
    csr_raddr_i = '0;
    csr_wren_i = 1'b0;
    csr_waddr_i = '0;
    csr_wdata_i = '0;

    add_load("ld_f1_one", 5'd1, 32'h3f800000);
    add_load("ld_f2_two", 5'd2, 32'h40000000);
    add_load("ld_f3_neg_one", 5'd3, 32'hbf800000);
    add_load("ld_f4_pos_zero", 5'd4, 32'h00000000);
    add_load("ld_f5_neg_zero", 5'd5, 32'h80000000);
    add_load("ld_f6_qnan", 5'd6, 32'h7fc00000);
    add_load("ld_f7_snan", 5'd7, 32'h7f800001);
    add_load("ld_f8_neg_inf", 5'd8, 32'hff800000);
    add_load("ld_f9_pos_inf", 5'd9, 32'h7f800000);
    add_load("ld_f10_pos_sub", 5'd10, 32'h00000001);
    add_load("ld_f11_neg_sub", 5'd11, 32'h80000001);
    add_load("ld_f12_rand", 5'd12, rnd0);
    add_move_out("mv_fwd_f12", 5'd12, rnd0);            // Bypass path
    add_load("ld_f13_rand", 5'd13, rnd1);
    add_move_out("mv_fwd_f13", 5'd13, rnd1);
    add_move_out("mv_mem_f12", 5'd12, rnd0);            // From storage

    add_fp_result("fsgnj", `FUNCT5_FSGNJ, `FUNCT3_FSGNJ, 5'd14, 5'd1, 5'd3, 32'hbf800000);
    add_fp_result("fsgnjn_rand", `FUNCT5_FSGNJ, `FUNCT3_FSGNJN, 5'd15, 5'd12, 5'd13,
                  {~rnd1[31], rnd0[30:0]});
    add_fp_result("fsgnjx_neg", `FUNCT5_FSGNJ, `FUNCT3_FSGNJX, 5'd16, 5'd3, 5'd3, 32'h3f800000);
    add_fp_result("fsgnjx_rand", `FUNCT5_FSGNJ, `FUNCT3_FSGNJX, 5'd17, 5'd12, 5'd13,
                  {rnd0[31] ^ rnd1[31], rnd0[30:0]});

    // Flag reads see the flag ops issued two rows earlier or before
    add_cmp("feq_qnan", `FUNCT3_FEQ, 5'd10, 5'd6, 5'd1, 32'd0);
    add_cmp("fle_equal", `FUNCT3_FLE, 5'd11, 5'd1, 5'd1, 32'd1);
    add_cmp("flt_qnan", `FUNCT3_FLT, 5'd12, 5'd6, 5'd1, 32'd0);
    csr_read(n_rows - 1, `CSR_FFLAGS, 32'd0, 1'b1);
    add_cmp("feq_zeros", `FUNCT3_FEQ, 5'd13, 5'd4, 5'd5, 32'd1);
    add_cmp("fle_qnan", `FUNCT3_FLE, 5'd19, 5'd1, 5'd6, 32'd0);
    add_cmp("flt_less", `FUNCT3_FLT, 5'd14, 5'd3, 5'd1, 32'd1);
    csr_read(n_rows - 1, `CSR_FFLAGS, nv, 1'b1);
    add_cmp("fle_zeros", `FUNCT3_FLE, 5'd15, 5'd5, 5'd4, 32'd1);
    csr_read(n_rows - 1, `CSR_FFLAGS, nv, 1'b1);
    add_cmp("flt_zeros", `FUNCT3_FLT, 5'd16, 5'd5, 5'd4, 32'd0);
    csr_read(n_rows - 1, `CSR_FFLAGS, nv, 1'b1);
    csr_write(n_rows - 1, `CSR_FFLAGS, 32'd0);
    add_cmp("feq_equal", `FUNCT3_FEQ, 5'd17, 5'd1, 5'd1, 32'd1);
    csr_read(n_rows - 1, `CSR_FFLAGS, 32'd0, 1'b1);
    add_cmp("flt_greater", `FUNCT3_FLT, 5'd18, 5'd2, 5'd1, 32'd0);
    csr_write(n_rows - 1, `CSR_FRM, 32'd5);

    add_fp_result("fmin", `FUNCT5_FMINMAX, `FUNCT3_FMIN, 5'd18, 5'd1, 5'd3, 32'hbf800000);
    add_fp_result("fmax", `FUNCT5_FMINMAX, `FUNCT3_FMAX, 5'd19, 5'd1, 5'd2, 32'h40000000);
    add_fp_result("fmin_zeros", `FUNCT5_FMINMAX, `FUNCT3_FMIN, 5'd20, 5'd4, 5'd5, 32'h80000000);
    add_fp_result("fmax_zeros", `FUNCT5_FMINMAX, `FUNCT3_FMAX, 5'd21, 5'd5, 5'd4, 32'h00000000);
    add_fp_result("fmin_one_nan", `FUNCT5_FMINMAX, `FUNCT3_FMIN, 5'd22, 5'd6, 5'd2, 32'h40000000);
    add_fp_result("fmax_two_nan", `FUNCT5_FMINMAX, `FUNCT3_FMAX, 5'd23, 5'd6, 5'd7, `FP_QNAN);

    // Classes in mask order starting at -inf
    k = n_rows;
    for (i = 0; i < 10; i++) begin
      add_int($sformatf("fclass_bit%0d", i), enc(`FUNCT5_FMV_X, `FUNCT3_FCLASS, 5'd24,
              cls_reg[i], 5'd0), 5'd24, 32'd1 << i);
    end
    csr_read(k, `CSR_FCSR, {24'd0, 3'd5, nv[4:0]}, 1'b1);
    csr_read(k + 1, 12'h004, 32'd0, 1'b0);
    csr_read(k + 2, `CSR_FRM, 32'd5, 1'b1);

    add_row("illegal_fmt", enc(`FUNCT5_FMV_W, `FUNCT3_FMV, 5'd1, 5'd0, 5'd0) | 32'h0200_0000,
            32'hdeadbeef, 1'b0, '0, '0, 1'b1);
    add_row("illegal_fadd", enc(5'b00000, 3'b000, 5'd1, 5'd2, 5'd3), '0, 1'b0, '0, '0, 1'b1);
    add_move_out("f1_unchanged", 5'd1, 32'h3f800000);

    cycle_limit = n_rows + 50;

    repeat (4) @(posedge clk);
    rst <= 1'b1;

    for (i = 0; i <= n_rows; i++) begin
      @(posedge clk);
      if (i < n_rows) apply_row(i);
      else apply_idle();
      @(negedge clk);
      if (i < n_rows && rows[i].csr_rd) begin
        check_value(i, "csr_ready", rows[i].exp_ready, csr_ready_o);
        check_value(i, "csr_rdata", rows[i].exp_csr, csr_rdata_o);
      end
      if (i > 0) begin
        check_value(i - 1, "illegal", rows[i - 1].exp_illegal, illegal_o);
        check_value(i - 1, "int_wren", rows[i - 1].exp_wren, int_wb_o.wren);
        if (rows[i - 1].exp_wren) begin
          check_value(i - 1, "int_addr", rows[i - 1].exp_addr, int_wb_o.addr);
          check_value(i - 1, "int_data", rows[i - 1].exp_data, int_wb_o.data);
        end
        $display("test %s: %s", rows[i - 1].name, (row_errs[i - 1] == 0) ? "ok" : "mismatch");
      end
    end

    $display("%0d tests run, %0d errors", n_rows, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
fpu_pkg.sv
fpu_decode.sv
fpu_regfile.sv
fpu_misc_exe.sv
fpu_csr.sv
fpu_core.sv
fpu_tb.sv
